// File: rtl/core_pkg.sv
package core_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [63:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes
  localparam logic [6:0] OP_IMM  = 7'h13;
  localparam logic [6:0] OP_REG  = 7'h33;
  localparam logic [6:0] OP_LUI  = 7'h37;
  // halts the core, code taken from x10
  localparam logic [6:0] OP_TRAP = 7'h6b;

  // funct3 of the alu group
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct7 for register ops
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // trap register index
  localparam reg_idx_t TRAP_REG = 5'd10;

  typedef enum logic {
    EXEC_RUN,
    EXEC_HALTED
  } exec_state_t;

endpackage

// File: rtl/inst_stream_if.sv
interface inst_stream_if;
  import core_pkg::*;

  logic  valid;
  logic  ready;
  addr_t pc;
  inst_t inst;

  // transfer when valid and ready meet on an edge
  modport source (
    output valid,
    output pc,
    output inst,
    input  ready
  );

  modport sink (
    input  valid,
    input  pc,
    input  inst,
    output ready
  );

endinterface

// File: rtl/fetch_unit.sv
module fetch_unit #(
  parameter core_pkg::addr_t RESET_PC = '0
) (
  input  logic            clock,
  input  logic            reset,
  output logic            imem_req_valid_o,
  output core_pkg::addr_t imem_req_addr_o,
  input  logic            imem_req_ready_i,
  input  logic            imem_rsp_valid_i,
  input  core_pkg::inst_t imem_rsp_data_i,
  inst_stream_if.source   out_o
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_WAIT,
    FETCH_OFFER
  } fetch_state_t;

  fetch_state_t state;
  addr_t        fetch_pc;
  inst_t        hold_inst;

  assign imem_req_valid_o = (state == FETCH_REQ);
  assign imem_req_addr_o  = fetch_pc;

  // held word keeps the pc it came from until it leaves
  assign out_o.valid = (state == FETCH_OFFER);
  assign out_o.pc    = fetch_pc;
  assign out_o.inst  = hold_inst;

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= FETCH_IDLE;
      fetch_pc <= RESET_PC;
    end else begin
      case (state)
        FETCH_IDLE: begin
          state <= FETCH_REQ;
        end
        FETCH_REQ: begin
          if (imem_req_ready_i) begin
            state <= FETCH_WAIT;
          end
        end
        FETCH_WAIT: begin
          if (imem_rsp_valid_i) begin
            state <= FETCH_OFFER;
          end
        end
        FETCH_OFFER: begin
          // advance only once the queue took the word
          if (out_o.ready) begin
            state    <= FETCH_REQ;
            fetch_pc <= fetch_pc + addr_t'(4);
          end
        end
        default: begin
          state <= FETCH_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == FETCH_WAIT && imem_rsp_valid_i) begin
      hold_inst <= imem_rsp_data_i;
    end
  end

endmodule

// File: rtl/inst_queue.sv
module inst_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic          clock,
  input  logic          reset,
  inst_stream_if.sink   in_i,
  inst_stream_if.source out_o
);
  import core_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  addr_t            pc_mem   [QUEUE_DEPTH];
  inst_t            inst_mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign in_i.ready  = (count != CNT_W'(QUEUE_DEPTH));
  assign out_o.valid = (count != '0);
  assign out_o.pc    = pc_mem[rd_ptr];
  assign out_o.inst  = inst_mem[rd_ptr];

  assign push = in_i.valid && in_i.ready;
  assign pop  = out_o.valid && out_o.ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (push && !pop) begin
        count <= count + CNT_W'(1);
      end else if (pop && !push) begin
        count <= count - CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      pc_mem[wr_ptr]   <= in_i.pc;
      inst_mem[wr_ptr] <= in_i.inst;
    end
  end

endmodule

// File: rtl/reg_file.sv
module reg_file (
  input  logic               clock,
  input  logic               reset,
  input  core_pkg::reg_idx_t rs1_i,
  input  core_pkg::reg_idx_t rs2_i,
  input  core_pkg::reg_idx_t rd_i,
  input  logic               wen_i,
  input  core_pkg::xlen_t    wdata_i,
  output core_pkg::xlen_t    rs1_data_o,
  output core_pkg::xlen_t    rs2_data_o
);
  import core_pkg::*;

  xlen_t regs [32];

  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && rd_i != '0) begin
      // x0 stays at its reset value
      regs[rd_i] <= wdata_i;
    end
  end

endmodule

// File: rtl/exec_unit.sv
module exec_unit (
  input  logic               clock,
  input  logic               reset,
  inst_stream_if.sink        in_i,
  output logic               commit_valid_o,
  output core_pkg::addr_t    commit_pc_o,
  output core_pkg::inst_t    commit_inst_o,
  output logic               commit_wen_o,
  output core_pkg::reg_idx_t commit_rd_o,
  output core_pkg::xlen_t    commit_wdata_o,
  output logic               halt_o,
  output logic [7:0]         trap_code_o
);
  import core_pkg::*;

  exec_state_t state;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  reg_idx_t    rd;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  xlen_t       rs1_data;
  xlen_t       rs2_data;
  xlen_t       imm;
  xlen_t       result;
  logic        supported;
  logic        is_trap;
  logic        accept;
  logic        wen;

  assign opcode = in_i.inst[6:0];
  assign rd     = in_i.inst[11:7];
  assign funct3 = in_i.inst[14:12];
  assign rs2    = in_i.inst[24:20];
  assign funct7 = in_i.inst[31:25];
  assign imm    = {{52{in_i.inst[31]}}, in_i.inst[31:20]};

  assign is_trap = (opcode == OP_TRAP);
  // trap code is read through the rs1 port
  assign rs1     = is_trap ? TRAP_REG : in_i.inst[19:15];

  assign in_i.ready = (state == EXEC_RUN);
  assign accept     = in_i.valid && in_i.ready;
  assign wen        = accept && supported && (rd != '0);
  assign halt_o     = (state == EXEC_HALTED);

  always_comb begin
    supported = 1'b0;
    result    = '0;
    case (opcode)
      OP_IMM: begin
        supported = 1'b1;
        case (funct3)
          F3_ADD:  result = rs1_data + imm;
          F3_XOR:  result = rs1_data ^ imm;
          F3_OR:   result = rs1_data | imm;
          F3_AND:  result = rs1_data & imm;
          default: supported = 1'b0;
        endcase
      end
      OP_REG: begin
        supported = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, F3_ADD}: result = rs1_data + rs2_data;
          {F7_SUB, F3_ADD}:  result = rs1_data - rs2_data;
          {F7_BASE, F3_XOR}: result = rs1_data ^ rs2_data;
          {F7_BASE, F3_OR}:  result = rs1_data | rs2_data;
          {F7_BASE, F3_AND}: result = rs1_data & rs2_data;
          default:           supported = 1'b0;
        endcase
      end
      OP_LUI: begin
        supported = 1'b1;
        result    = {{32{in_i.inst[31]}}, in_i.inst[31:12], 12'h000};
      end
      default: begin
        supported = 1'b0;
      end
    endcase
  end

  reg_file u_reg_file (
    .clock      (clock),
    .reset      (reset),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rd_i       (rd),
    .wen_i      (wen),
    .wdata_i    (result),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      state          <= EXEC_RUN;
      commit_valid_o <= 1'b0;
    end else begin
      commit_valid_o <= accept;
      // halted until the next reset
      if (accept && is_trap) begin
        state <= EXEC_HALTED;
      end
    end
  end

  // commit record, one cycle behind acceptance
  always_ff @(posedge clock) begin
    if (accept) begin
      commit_pc_o    <= in_i.pc;
      commit_inst_o  <= in_i.inst;
      commit_wen_o   <= wen;
      commit_rd_o    <= rd;
      commit_wdata_o <= result;
      if (is_trap) begin
        trap_code_o <= rs1_data[7:0];
      end
    end
  end

endmodule

// File: rtl/core_top.sv
module core_top #(
  parameter core_pkg::addr_t RESET_PC    = '0,
  parameter int              QUEUE_DEPTH = 4
) (
  input  logic               clock,
  input  logic               reset,
  output logic               imem_req_valid_o,
  output core_pkg::addr_t    imem_req_addr_o,
  input  logic               imem_req_ready_i,
  input  logic               imem_rsp_valid_i,
  input  core_pkg::inst_t    imem_rsp_data_i,
  output logic               commit_valid_o,
  output core_pkg::addr_t    commit_pc_o,
  output core_pkg::inst_t    commit_inst_o,
  output logic               commit_wen_o,
  output core_pkg::reg_idx_t commit_rd_o,
  output core_pkg::xlen_t    commit_wdata_o,
  output logic               halt_o,
  output logic [7:0]         trap_code_o
);

  inst_stream_if fetch_q ();
  inst_stream_if queue_x ();

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) u_fetch_unit (
    .clock            (clock),
    .reset            (reset),
    .imem_req_valid_o (imem_req_valid_o),
    .imem_req_addr_o  (imem_req_addr_o),
    .imem_req_ready_i (imem_req_ready_i),
    .imem_rsp_valid_i (imem_rsp_valid_i),
    .imem_rsp_data_i  (imem_rsp_data_i),
    .out_o            (fetch_q.source)
  );

  inst_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_inst_queue (
    .clock (clock),
    .reset (reset),
    .in_i  (fetch_q.sink),
    .out_o (queue_x.source)
  );

  exec_unit u_exec_unit (
    .clock          (clock),
    .reset          (reset),
    .in_i           (queue_x.sink),
    .commit_valid_o (commit_valid_o),
    .commit_pc_o    (commit_pc_o),
    .commit_inst_o  (commit_inst_o),
    .commit_wen_o   (commit_wen_o),
    .commit_rd_o    (commit_rd_o),
    .commit_wdata_o (commit_wdata_o),
    .halt_o         (halt_o),
    .trap_code_o    (trap_code_o)
  );

endmodule

// File: tests/tb_imem.sv
module tb_imem #(
  parameter logic [63:0] RESET_PC = '0,
  parameter int          PROG_LEN = 60
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        req_valid_i,
  input  logic [63:0] req_addr_i,
  output logic        req_ready_o,
  output logic        rsp_valid_o,
  output logic [31:0] rsp_data_o,
  input  logic [31:0] prog_i [PROG_LEN],
  output int          req_count_o,
  output logic [63:0] last_addr_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] lfsr;
  logic        busy;
  int          wait_cnt;
  int          lat_cnt;
  logic [63:0] pend_addr;

  task automatic load_seed(input logic [31:0] seed);
    lfsr = seed;
  endtask

  // galois lfsr, one step per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        bit_out;
    val = '0;
    for (int i = 0; i < n; i++) begin
      bit_out = lfsr[0];
      lfsr = lfsr >> 1;
      if (bit_out) begin
        lfsr = lfsr ^ 32'h8020_0003;
      end
      val = {val[30:0], bit_out};
    end
    return val;
  endfunction

  function automatic logic [31:0] word_at(input logic [63:0] addr);
    logic [63:0] offs;
    offs = addr - RESET_PC;
    if (offs[1:0] == 2'b00 && (offs >> 2) < 64'(PROG_LEN)) begin
      return prog_i[int'(offs >> 2)];
    end
    // past the program
    return addr[31:0] ^ addr[63:32] ^ 32'h0bad_f00d;
  endfunction

  initial begin
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
    req_count_o = 0;
    last_addr_o = '0;
  end

  always @(negedge clock) begin
    if (reset) begin
      busy     = 1'b0;
      wait_cnt = -1;
      lat_cnt  = 0;
      req_ready_o <= 1'b0;
      rsp_valid_o <= 1'b0;
      req_count_o <= 0;
    end else begin
      rsp_valid_o <= 1'b0;
      if (req_ready_o) begin
        // valid was held, so the request went in at the last rising edge
        req_ready_o <= 1'b0;
        busy    = 1'b1;
        lat_cnt = 1 + int'(rand_bits(2));
        req_count_o <= req_count_o + 1;
        last_addr_o <= pend_addr;
      end else if (!busy && req_valid_i) begin
        if (wait_cnt < 0) begin
          wait_cnt = int'(rand_bits(2));
        end
        if (wait_cnt == 0) begin
          req_ready_o <= 1'b1;
          pend_addr = req_addr_i;
          wait_cnt  = -1;
        end else begin
          wait_cnt--;
        end
      end
      if (busy) begin
        lat_cnt--;
        if (lat_cnt == 0) begin
          rsp_valid_o <= 1'b1;
          rsp_data_o  <= word_at(pend_addr);
          busy = 1'b0;
        end
      end
    end
  end

endmodule

// File: tests/tb_core.sv
module tb_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [63:0] RESET_PC     = 64'h8000_0000;
  localparam int          QUEUE_DEPTH  = 4;
  localparam int          PROG_LEN     = 60;
  localparam logic [31:0] LFSR_SEED    = 32'h55cf;
  localparam int          CYCLE_LIMIT  = PROG_LEN * (4 + 4 + 2) + 100;
  localparam int          DRAIN_CYCLES = 50;
  localparam int          QUIET_CYCLES = 20;
  localparam int          NUM_TESTS    = 5;

  logic        clock;
  logic        reset;
  logic        imem_req_valid;
  logic [63:0] imem_req_addr;
  logic        imem_req_ready;
  logic        imem_rsp_valid;
  logic [31:0] imem_rsp_data;
  logic        commit_valid;
  logic [63:0] commit_pc;
  logic [31:0] commit_inst;
  logic        commit_wen;
  logic [4:0]  commit_rd;
  logic [63:0] commit_wdata;
  logic        halt;
  logic [7:0]  trap_code;
  int          req_count;
  logic [63:0] last_addr;

  logic [31:0] prog [PROG_LEN];
  logic [63:0] model [32];
  int          err_cnt [NUM_TESTS];
  int          commit_count;
  int          quiet_run;
  logic        first_req_seen;
  logic        halt_seen;

  core_top #(
    .RESET_PC    (RESET_PC),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) core_top_i (
    .clock            (clock),
    .reset            (reset),
    .imem_req_valid_o (imem_req_valid),
    .imem_req_addr_o  (imem_req_addr),
    .imem_req_ready_i (imem_req_ready),
    .imem_rsp_valid_i (imem_rsp_valid),
    .imem_rsp_data_i  (imem_rsp_data),
    .commit_valid_o   (commit_valid),
    .commit_pc_o      (commit_pc),
    .commit_inst_o    (commit_inst),
    .commit_wen_o     (commit_wen),
    .commit_rd_o      (commit_rd),
    .commit_wdata_o   (commit_wdata),
    .halt_o           (halt),
    .trap_code_o      (trap_code)
  );

  tb_imem #(
    .RESET_PC (RESET_PC),
    .PROG_LEN (PROG_LEN)
  ) imem_i (
    .clock       (clock),
    .reset       (reset),
    .req_valid_i (imem_req_valid),
    .req_addr_i  (imem_req_addr),
    .req_ready_o (imem_req_ready),
    .rsp_valid_o (imem_rsp_valid),
    .rsp_data_o  (imem_rsp_data),
    .prog_i      (prog),
    .req_count_o (req_count),
    .last_addr_o (last_addr)
  );

  function automatic string test_name(input int test);
    case (test)
      1:       return "reset state";
      2:       return "program order";
      3:       return "results";
      4:       return "trap";
      default: return "back-pressure bound";
    endcase
  endfunction

  task automatic report_value(input int test, input string name,
                              input logic [63:0] expected, input logic [63:0] actual);
    err_cnt[test - 1]++;
    $display("Fail at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
  endtask

  task automatic report_event(input int test, input string what);
    err_cnt[test - 1]++;
    $display("test %0d went wrong at %0d ns: %s", test, $time, what);
  endtask

  task automatic report_test(input int test);
    if (err_cnt[test - 1] == 0) begin
      $display("test %0d %s: ok", test, test_name(test));
    end else begin
      $display("test %0d %s: %0d errors", test, test_name(test), err_cnt[test - 1]);
    end
  endtask

  task automatic gen_program();
    logic [3:0]  kind;
    logic [2:0]  sel;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [6:0]  bad_op;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      kind = 4'(imem_i.rand_bits(4));
      // x0 to x15 only, so results come back as sources
      rd  = 5'(imem_i.rand_bits(4));
      rs1 = 5'(imem_i.rand_bits(4));
      rs2 = 5'(imem_i.rand_bits(4));
      imm = 12'(imem_i.rand_bits(12));
      sel = 3'(imem_i.rand_bits(3));
      case (sel)
        3'd1:    f3 = 3'b100;
        3'd2:    f3 = 3'b110;
        3'd3:    f3 = 3'b111;
        default: f3 = 3'b000;
      endcase
      f7 = (sel >= 3'd4) ? 7'h20 : 7'h00;
      case (sel[1:0])
        2'd0:    bad_op = 7'h03;
        2'd1:    bad_op = 7'h23;
        2'd2:    bad_op = 7'h63;
        default: bad_op = 7'h73;
      endcase
      case (kind)
        4'd0, 4'd1, 4'd2, 4'd3, 4'd4: prog[i] = {imm, rs1, f3, rd, 7'h13};
        4'd5, 4'd6, 4'd7, 4'd8, 4'd9, 4'd10: prog[i] = {f7, rs2, rs1, f3, rd, 7'h33};
        4'd11, 4'd12: prog[i] = {imm, rs1, f3, rd, 7'h37};
        4'd13: prog[i] = {imm, rs1, f3, rd, bad_op};
        // slli encoding, not in the supported set
        4'd14: prog[i] = {imm, rs1, 3'b001, rd, 7'h13};
        default: prog[i] = {7'h01, rs2, rs1, f3, rd, 7'h33};
      endcase
    end
    prog[PROG_LEN - 1] = 32'h0000_006b;
  endtask

  // expected write-back of one instruction against the model registers
  task automatic ref_exec(input logic [31:0] inst, output logic wen, output logic [63:0] value);
    logic [63:0] rs1v;
    logic [63:0] rs2v;
    logic [63:0] imm;
    logic        ok;
    rs1v  = model[inst[19:15]];
    rs2v  = model[inst[24:20]];
    imm   = {{52{inst[31]}}, inst[31:20]};
    ok    = 1'b1;
    value = '0;
    case (inst[6:0])
      7'h13: begin
        case (inst[14:12])
          3'b000:  value = rs1v + imm;
          3'b100:  value = rs1v ^ imm;
          3'b110:  value = rs1v | imm;
          3'b111:  value = rs1v & imm;
          default: ok = 1'b0;
        endcase
      end
      7'h33: begin
        if (inst[31:25] == 7'h20 && inst[14:12] == 3'b000) begin
          value = rs1v - rs2v;
        end else if (inst[31:25] != 7'h00) begin
          ok = 1'b0;
        end else begin
          case (inst[14:12])
            3'b000:  value = rs1v + rs2v;
            3'b100:  value = rs1v ^ rs2v;
            3'b110:  value = rs1v | rs2v;
            3'b111:  value = rs1v & rs2v;
            default: ok = 1'b0;
          endcase
        end
      end
      7'h37: value = {{32{inst[31]}}, inst[31:12], 12'h000};
      default: ok = 1'b0;
    endcase
    wen = ok && (inst[11:7] != 5'd0);
  endtask

  task automatic check_commit();
    logic [31:0] inst;
    logic [63:0] exp_pc;
    logic [63:0] exp_wdata;
    logic        exp_wen;
    assert (!halt_seen)
      else report_event(4, "commit_valid_o pulsed after the trap had committed");
    if (halt_seen) begin
      return;
    end
    inst   = prog[commit_count];
    exp_pc = RESET_PC + 64'(4 * commit_count);
    assert (commit_pc == exp_pc) else report_value(2, "commit_pc_o", exp_pc, commit_pc);
    assert (commit_inst == inst)
      else report_value(2, "commit_inst_o", 64'(inst), 64'(commit_inst));
    ref_exec(inst, exp_wen, exp_wdata);
    assert (commit_wen == exp_wen)
      else report_value(3, "commit_wen_o", 64'(exp_wen), 64'(commit_wen));
    if (exp_wen) begin
      assert (commit_rd == inst[11:7])
        else report_value(3, "commit_rd_o", 64'(inst[11:7]), 64'(commit_rd));
      assert (commit_wdata == exp_wdata)
        else report_value(3, "commit_wdata_o", exp_wdata, commit_wdata);
      model[inst[11:7]] = exp_wdata;
    end
    if (inst[6:0] == 7'h6b) begin
      assert (halt) else report_event(4, "halt_o stayed low on the trap commit");
      assert (trap_code == model[10][7:0])
        else report_value(4, "trap_code_o", 64'(model[10][7:0]), 64'(trap_code));
      halt_seen = 1'b1;
    end else begin
      assert (!halt) else report_event(4, "halt_o rose on a commit that is not the trap");
    end
    commit_count++;
  endtask

  task automatic check_cycle();
    if (!first_req_seen) begin
      assert (!commit_valid && !halt)
        else report_event(1, "commit_valid_o or halt_o rose before any fetch");
    end
    if (!first_req_seen && req_count != 0) begin
      first_req_seen = 1'b1;
      assert (last_addr == RESET_PC) else report_value(1, "imem_req_addr_o", RESET_PC, last_addr);
      report_test(1);
    end
    if (commit_valid) begin
      check_commit();
    end else if (!halt_seen) begin
      assert (!halt) else report_event(4, "halt_o rose without a trap commit");
    end
    if (halt_seen) begin
      assert (req_count <= commit_count + QUEUE_DEPTH + 1)
        else report_event(5, "more requests accepted than the queue and fetch can hold");
      quiet_run = imem_req_valid ? 0 : quiet_run + 1;
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  initial begin
    int   cycles;
    int   drain;
    int   total;
    int   passed;
    logic timed_out;
    reset = 1'b1;
    cycles = 0;
    drain  = 0;
    commit_count   = 0;
    quiet_run      = 0;
    first_req_seen = 1'b0;
    halt_seen      = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      err_cnt[t] = 0;
    end
    for (int r = 0; r < 32; r++) begin
      model[r] = '0;
    end
    imem_i.load_seed(LFSR_SEED);
    gen_program();

    repeat (10) begin
      @(negedge clock);
      assert (!imem_req_valid && !commit_valid && !halt)
        else report_event(1, "a valid or halt output was high during reset");
    end
    reset <= 1'b0;

    while (!(halt_seen && drain == DRAIN_CYCLES) && cycles < CYCLE_LIMIT) begin
      @(negedge clock);
      cycles++;
      check_cycle();
      if (halt_seen) begin
        drain++;
      end
    end

    timed_out = !(halt_seen && drain == DRAIN_CYCLES);
    if (timed_out) begin
      $display("run hit the limit of %0d cycles before the core halted and drained",
               CYCLE_LIMIT);
    end else begin
      assert (quiet_run >= QUIET_CYCLES)
        else report_event(5, "imem_req_valid_o kept rising after the halt");
    end
    if (!first_req_seen) begin
      report_test(1);
    end
    for (int t = 2; t <= NUM_TESTS; t++) begin
      report_test(t);
    end

    total  = 0;
    passed = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total += err_cnt[t];
      if (err_cnt[t] == 0) begin
        passed++;
      end
    end
    $display("%0d of %0d tests passed, %0d failed checks, %0d commits",
             passed, NUM_TESTS, total, commit_count);
    if (!timed_out && total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
rtl/core_pkg.sv
rtl/inst_stream_if.sv
rtl/fetch_unit.sv
rtl/inst_queue.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/core_top.sv
tests/tb_imem.sv
tests/tb_core.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_core --Mdir obj_dir -f flist.f

./obj_dir/Vtb_core > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "run.sh: simulation reported failure"
  exit 1
fi

echo "run.sh: simulation done"
exit 0
